/* source/netProtoPkg.sv */
package netProtoPkg;

	////////////////////////////////////////////////////////////////////////////
	// address and number types
	////////////////////////////////////////////////////////////////////////////

	typedef logic [47:0] macAddrT;
	typedef logic [31:0] ipAddrT;
	typedef logic [15:0] tcpPortT;
	typedef logic [31:0] seqNumT;

	////////////////////////////////////////////////////////////////////////////
	// ethernet
	////////////////////////////////////////////////////////////////////////////

	localparam logic [7:0] ETHERTYPE_IPV4_HI = 8'h08;	// 0x0800
	localparam logic [7:0] ETHERTYPE_IPV4_LO = 8'h00;
	localparam logic [7:0] ETHERTYPE_VLAN_HI = 8'h81;	// 802.1Q TPID 0x8100

	////////////////////////////////////////////////////////////////////////////
	// ipv4 and tcp
	////////////////////////////////////////////////////////////////////////////

	localparam logic [7:0] IP_PROTO_TCP = 8'd6;

	// header lengths in 32 bit words, no options
	localparam logic [3:0] IPV4_BASE_WORDS = 4'd5;
	localparam logic [3:0] TCP_BASE_WORDS  = 4'd5;

	// 20 bytes ip + 20 bytes tcp
	localparam logic [15:0] BASE_HEADER_BYTES = 16'd40;

	localparam int unsigned TCP_FLAG_SYN_BIT = 1;	// within the flags byte

endpackage

/* source/parserPkg.sv */
package parserPkg;
	import netProtoPkg::*;

	// one byte of a stream, valid may drop between bytes
	typedef struct packed {
		logic       valid;
		logic [7:0] data;
	} rxByteT;

	// the connection we follow
	typedef struct packed {
		ipAddrT  srcIp;
		ipAddrT  dstIp;
		tcpPortT srcPort;
		tcpPortT dstPort;
	} sessionT;

	typedef enum logic [3:0] {
		NONE, MAC_DST, HDR_SKIP, IP_VER, IP_LEN, IP_PROTO, IP_SRC, IP_DST,
		TCP_SRCPORT, TCP_DSTPORT, TCP_SEQ, TCP_OFFSET, TCP_FLAGS, OPTION, PAYLOAD
	} fieldSelT;

	// one state per header field
	typedef enum logic [4:0] {
		S_IDLE, S_MAC_DST, S_MAC_SRC, S_ETH_TYPE, S_VLAN_TAG,
		S_IP_VER, S_IP_TOS, S_IP_LEN, S_IP_MISC, S_IP_PROTO, S_IP_CSUM,
		S_IP_SRC, S_IP_DST, S_IP_OPT,
		S_TCP_SRCPORT, S_TCP_DSTPORT, S_TCP_SEQ, S_TCP_ACK, S_TCP_OFFSET,
		S_TCP_FLAGS, S_TCP_TAIL, S_TCP_OPT, S_PAYLOAD, S_DROP
	} parseStateT;

	typedef struct packed {
		logic       byteValid;
		logic [7:0] data;
		fieldSelT   field;
		logic [2:0] fieldIdx;	// byte within the field, 0 is the MSB
	} parseCtlT;

	typedef struct packed {
		logic pulse;	// last byte of the tcp header
	} headerEndT;

endpackage

/* source/frameParser.sv */
`timescale 1ns/1ps

module frameParser
	import netProtoPkg::*, parserPkg::*;
(
	input  logic      CLOCK,
	input  logic      rst,
	input  logic      newPkt,
	input  rxByteT    rxByte,
	input  logic      fieldLast,
	input  logic      optionsLeft,
	input  logic      payloadLast,
	output parseCtlT  parseCtl,
	output headerEndT tcpHeaderEnd
);

	parseStateT state;
	parseStateT stateNext;
	fieldSelT   fieldNow;
	logic [2:0] byteIdx;
	logic       vlanType;	// ethertype high byte was the 802.1Q one

	////////////////////////////////////////////////////////////////////////////
	// tag of the current byte
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (state)
			S_MAC_DST:     fieldNow = MAC_DST;
			S_MAC_SRC, S_ETH_TYPE, S_VLAN_TAG, S_IP_TOS, S_IP_MISC, S_IP_CSUM,
			S_TCP_ACK, S_TCP_TAIL:
				fieldNow = HDR_SKIP;
			S_IP_VER:      fieldNow = IP_VER;
			S_IP_LEN:      fieldNow = IP_LEN;
			S_IP_PROTO:    fieldNow = IP_PROTO;
			S_IP_SRC:      fieldNow = IP_SRC;
			S_IP_DST:      fieldNow = IP_DST;
			S_IP_OPT, S_TCP_OPT: fieldNow = OPTION;
			S_TCP_SRCPORT: fieldNow = TCP_SRCPORT;
			S_TCP_DSTPORT: fieldNow = TCP_DSTPORT;
			S_TCP_SEQ:     fieldNow = TCP_SEQ;
			S_TCP_OFFSET:  fieldNow = TCP_OFFSET;
			S_TCP_FLAGS:   fieldNow = TCP_FLAGS;
			S_PAYLOAD:     fieldNow = PAYLOAD;
			default:       fieldNow = NONE;	// idle and drop
		endcase
	end

	assign parseCtl = '{
		byteValid: rxByte.valid,
		data:      rxByte.data,
		field:     fieldNow,
		fieldIdx:  byteIdx
	};

	assign tcpHeaderEnd.pulse = rxByte.valid && fieldLast && !optionsLeft &&
		(state == S_TCP_TAIL || state == S_TCP_OPT);

	////////////////////////////////////////////////////////////////////////////
	// next field
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		stateNext = state;
		case (state)
			S_MAC_DST: if (fieldLast) stateNext = S_MAC_SRC;
			S_MAC_SRC: if (fieldLast) stateNext = S_ETH_TYPE;
			S_ETH_TYPE: begin
				if (byteIdx == 3'd0) begin
					// high byte decides early, anything else is not ours
					if (rxByte.data != ETHERTYPE_IPV4_HI && rxByte.data != ETHERTYPE_VLAN_HI)
						stateNext = S_DROP;
				end else if (fieldLast) begin
					if (vlanType)
						stateNext = S_VLAN_TAG;
					else if (rxByte.data == ETHERTYPE_IPV4_LO)
						stateNext = S_IP_VER;
					else
						stateNext = S_DROP;
				end
			end
			S_VLAN_TAG: if (fieldLast) stateNext = S_ETH_TYPE;	// TCI then real ethertype
			S_IP_VER:   stateNext = S_IP_TOS;
			S_IP_TOS:   stateNext = S_IP_LEN;
			S_IP_LEN:   if (fieldLast) stateNext = S_IP_MISC;
			S_IP_MISC:  if (fieldLast) stateNext = S_IP_PROTO;
			S_IP_PROTO: stateNext = (rxByte.data == IP_PROTO_TCP) ? S_IP_CSUM : S_DROP;
			S_IP_CSUM:  if (fieldLast) stateNext = S_IP_SRC;
			S_IP_SRC:   if (fieldLast) stateNext = S_IP_DST;
			S_IP_DST, S_IP_OPT: begin
				if (fieldLast)
					stateNext = optionsLeft ? S_IP_OPT : S_TCP_SRCPORT;
			end
			S_TCP_SRCPORT: if (fieldLast) stateNext = S_TCP_DSTPORT;
			S_TCP_DSTPORT: if (fieldLast) stateNext = S_TCP_SEQ;
			S_TCP_SEQ:     if (fieldLast) stateNext = S_TCP_ACK;
			S_TCP_ACK:     if (fieldLast) stateNext = S_TCP_OFFSET;
			S_TCP_OFFSET:  stateNext = S_TCP_FLAGS;
			S_TCP_FLAGS:   stateNext = S_TCP_TAIL;
			S_TCP_TAIL, S_TCP_OPT: begin
				if (fieldLast) begin
					if (optionsLeft)
						stateNext = S_TCP_OPT;
					else
						stateNext = payloadLast ? S_IDLE : S_PAYLOAD;	// no data, e.g. a bare SYN
				end
			end
			S_PAYLOAD: if (payloadLast) stateNext = S_IDLE;
			default: stateNext = state;	// idle and drop wait for newPkt
		endcase
	end

	always_ff @(posedge CLOCK) begin
		if (rst) begin
			state   <= S_IDLE;
			byteIdx <= 3'd0;
		end else if (newPkt) begin
			state   <= S_MAC_DST;
			byteIdx <= 3'd0;
		end else if (rxByte.valid) begin
			state   <= stateNext;
			byteIdx <= (fieldLast || stateNext != state) ? 3'd0 : byteIdx + 3'd1;
		end
	end

	always_ff @(posedge CLOCK) begin
		if (rxByte.valid && state == S_ETH_TYPE && byteIdx == 3'd0)
			vlanType <= rxByte.data == ETHERTYPE_VLAN_HI;
	end

	// payload only once every option word has gone by
	assert property (@(posedge CLOCK) disable iff (rst)
		parseCtl.byteValid && parseCtl.field == PAYLOAD |-> !optionsLeft)
		else $error("payload tagged while option words remain");

endmodule

/* source/headerCounter.sv */
`timescale 1ns/1ps

module headerCounter
	import netProtoPkg::*, parserPkg::*;
(
	input  logic     CLOCK,
	input  logic     rst,
	input  logic     newPkt,
	input  parseCtlT parseCtl,
	output logic     fieldLast,
	output logic     optionsLeft,
	output logic     payloadLast
);

	fieldSelT    prevField;	// last completed field, sizes the skip runs
	logic [2:0]  fieldLen;
	logic [2:0]  fieldLeft;
	logic [2:0]  curLeft;
	logic [3:0]  ipWordsLeft;
	logic [3:0]  tcpWordsLeft;
	logic [15:0] payloadLeft;
	logic        countsPayload;

	always_comb begin
		case (parseCtl.field)
			MAC_DST: fieldLen = 3'd6;
			HDR_SKIP: begin
				case (prevField)
					MAC_DST:   fieldLen = 3'd6;	// source mac
					IP_VER:    fieldLen = 3'd1;	// tos
					IP_LEN:    fieldLen = 3'd5;	// id, frag, ttl
					IP_PROTO:  fieldLen = 3'd2;	// ip checksum
					TCP_SEQ:   fieldLen = 3'd4;	// ack number
					TCP_FLAGS: fieldLen = 3'd6;	// window, checksum, urgent
					default:   fieldLen = 3'd2;	// ethertype or vlan TCI
				endcase
			end
			IP_LEN, TCP_SRCPORT, TCP_DSTPORT: fieldLen = 3'd2;
			IP_SRC, IP_DST, TCP_SEQ, OPTION, PAYLOAD: fieldLen = 3'd4;
			default: fieldLen = 3'd1;
		endcase
	end

	assign curLeft       = (parseCtl.fieldIdx == 3'd0) ? fieldLen : fieldLeft;
	assign fieldLast     = curLeft == 3'd1;
	assign countsPayload = parseCtl.field == OPTION || parseCtl.field == PAYLOAD;
	assign optionsLeft   = ipWordsLeft != 4'd0 || tcpWordsLeft != 4'd0;
	// nothing left after this byte
	assign payloadLast   = countsPayload ? payloadLeft <= 16'd1 : payloadLeft == 16'd0;

	always_ff @(posedge CLOCK) begin
		if (rst || newPkt) begin
			prevField    <= NONE;
			fieldLeft    <= 3'd0;
			ipWordsLeft  <= 4'd0;
			tcpWordsLeft <= 4'd0;
			payloadLeft  <= 16'd0;
		end else if (parseCtl.byteValid) begin
			fieldLeft <= curLeft - 3'd1;
			if (fieldLast)
				prevField <= parseCtl.field;
			case (parseCtl.field)
				IP_VER: ipWordsLeft <= (parseCtl.data[3:0] > IPV4_BASE_WORDS) ?
					parseCtl.data[3:0] - IPV4_BASE_WORDS : 4'd0;
				IP_LEN: begin
					if (parseCtl.fieldIdx == 3'd0)
						payloadLeft <= {parseCtl.data, 8'h00};
					else
						payloadLeft <= {payloadLeft[15:8], parseCtl.data} - BASE_HEADER_BYTES;
				end
				TCP_OFFSET: tcpWordsLeft <= (parseCtl.data[7:4] > TCP_BASE_WORDS) ?
					parseCtl.data[7:4] - TCP_BASE_WORDS : 4'd0;
				OPTION: begin
					// one word gone at its first byte, ip options come first
					if (parseCtl.fieldIdx == 3'd0) begin
						if (ipWordsLeft != 4'd0)
							ipWordsLeft <= ipWordsLeft - 4'd1;
						else if (tcpWordsLeft != 4'd0)
							tcpWordsLeft <= tcpWordsLeft - 4'd1;
					end
					payloadLeft <= payloadLeft - 16'd1;
				end
				PAYLOAD: payloadLeft <= payloadLeft - 16'd1;
				default: ;
			endcase
		end
	end

	// ip total length must cover every option and payload byte the parser tags
	assert property (@(posedge CLOCK) disable iff (rst)
		!newPkt && parseCtl.byteValid && countsPayload |-> payloadLeft != 16'd0)
		else $error("remaining payload count underflow");

endmodule

/* source/sessionFilter.sv */
`timescale 1ns/1ps

module sessionFilter
	import netProtoPkg::*, parserPkg::*;
#(
	parameter macAddrT LOCAL_MAC = 48'h02_00_00_00_00_01
) (
	input  logic     CLOCK,
	input  logic     rst,
	input  logic     newPkt,
	input  parseCtlT parseCtl,
	input  sessionT  session,
	output logic     sessionHit,
	output rxByteT   payload,
	output logic     payloadStart
);

	logic [4:0] fieldHit;	// mac, src ip, dst ip, src port, dst port
	logic [4:0] fieldSel;
	logic [7:0] expByte;
	logic       byteMatch;
	logic       deliver;
	logic       firstPending;	// no payload byte out yet this frame
	logic       payValid;
	logic [7:0] payData;

	always_comb begin
		expByte  = 8'h00;
		fieldSel = 5'b00000;
		case (parseCtl.field)
			MAC_DST: begin
				expByte  = LOCAL_MAC[8 * (5 - parseCtl.fieldIdx) +: 8];
				fieldSel = 5'b00001;
			end
			IP_SRC: begin
				expByte  = session.srcIp[8 * (3 - parseCtl.fieldIdx) +: 8];
				fieldSel = 5'b00010;
			end
			IP_DST: begin
				expByte  = session.dstIp[8 * (3 - parseCtl.fieldIdx) +: 8];
				fieldSel = 5'b00100;
			end
			TCP_SRCPORT: begin
				expByte  = session.srcPort[8 * (1 - parseCtl.fieldIdx) +: 8];
				fieldSel = 5'b01000;
			end
			TCP_DSTPORT: begin
				expByte  = session.dstPort[8 * (1 - parseCtl.fieldIdx) +: 8];
				fieldSel = 5'b10000;
			end
			default: ;
		endcase
	end

	assign byteMatch  = parseCtl.data == expByte;
	assign sessionHit = &fieldHit;
	assign deliver    = parseCtl.byteValid && parseCtl.field == PAYLOAD && sessionHit;
	assign payload    = '{valid: payValid, data: payData};

	always_ff @(posedge CLOCK) begin
		if (rst || newPkt) begin
			fieldHit     <= 5'b00000;
			firstPending <= 1'b1;
			payValid     <= 1'b0;
			payloadStart <= 1'b0;
		end else begin
			payValid     <= deliver;
			payloadStart <= deliver && firstPending;
			if (deliver)
				firstPending <= 1'b0;
			if (parseCtl.byteValid) begin
				for (int k = 0; k < 5; k++) begin
					// first byte starts the field fresh, later bytes must keep matching
					if (fieldSel[k])
						fieldHit[k] <= byteMatch && (parseCtl.fieldIdx == 3'd0 || fieldHit[k]);
				end
			end
		end
	end

	always_ff @(posedge CLOCK) begin
		payData <= parseCtl.data;
	end

	// the match holds through the whole payload until the next frame start
	assert property (@(posedge CLOCK) disable iff (rst) payValid && !newPkt |=> sessionHit)
		else $error("session match lost during the payload");

endmodule

/* source/seqTracker.sv */
`timescale 1ns/1ps

module seqTracker
	import netProtoPkg::*, parserPkg::*;
(
	input  logic      CLOCK,
	input  logic      rst,
	input  parseCtlT  parseCtl,
	input  headerEndT tcpHeaderEnd,
	input  logic      sessionHit,
	input  rxByteT    payload,
	output logic      gapped
);

	seqNumT seqBuf;	// seq of the frame being parsed
	seqNumT expected;	// next seq we should see
	logic   synFlag;

	// header capture, msb arrives first
	always_ff @(posedge CLOCK) begin
		if (parseCtl.byteValid && parseCtl.field == TCP_SEQ)
			seqBuf <= {seqBuf[23:0], parseCtl.data};
		if (parseCtl.byteValid && parseCtl.field == TCP_FLAGS)
			synFlag <= parseCtl.data[TCP_FLAG_SYN_BIT];
	end

	always_ff @(posedge CLOCK) begin
		if (rst) begin
			expected <= '0;
			gapped   <= 1'b0;
		end else if (tcpHeaderEnd.pulse && sessionHit) begin
			if (synFlag) begin
				expected <= seqBuf + seqNumT'(1);	// SYN uses one sequence number
				gapped   <= 1'b0;
			end else begin
				gapped <= seqBuf != expected;
			end
		end else if (payload.valid) begin
			expected <= expected + seqNumT'(1);
		end
	end

endmodule

/* source/tcpStreamTop.sv */
`timescale 1ns/1ps

module tcpStreamTop
	import netProtoPkg::*, parserPkg::*;
#(
	parameter macAddrT LOCAL_MAC = 48'h02_00_00_00_00_01
) (
	input  logic    CLOCK,
	input  logic    rst,
	input  logic    newPkt,
	input  rxByteT  rxByte,
	input  sessionT session,
	output rxByteT  payload,
	output logic    payloadStart,
	output logic    gapped
);

	parseCtlT  parseCtl;
	headerEndT tcpHeaderEnd;
	logic      fieldLast;
	logic      optionsLeft;
	logic      payloadLast;
	logic      sessionHit;

	frameParser frameParser_inst (
		.CLOCK        (CLOCK),
		.rst          (rst),
		.newPkt       (newPkt),
		.rxByte       (rxByte),
		.fieldLast    (fieldLast),
		.optionsLeft  (optionsLeft),
		.payloadLast  (payloadLast),
		.parseCtl     (parseCtl),
		.tcpHeaderEnd (tcpHeaderEnd)
	);

	headerCounter headerCounter_inst (
		.CLOCK       (CLOCK),
		.rst         (rst),
		.newPkt      (newPkt),
		.parseCtl    (parseCtl),
		.fieldLast   (fieldLast),
		.optionsLeft (optionsLeft),
		.payloadLast (payloadLast)
	);

	sessionFilter #(
		.LOCAL_MAC (LOCAL_MAC)
	) sessionFilter_inst (
		.CLOCK        (CLOCK),
		.rst          (rst),
		.newPkt       (newPkt),
		.parseCtl     (parseCtl),
		.session      (session),
		.sessionHit   (sessionHit),
		.payload      (payload),
		.payloadStart (payloadStart)
	);

	seqTracker seqTracker_inst (
		.CLOCK        (CLOCK),
		.rst          (rst),
		.parseCtl     (parseCtl),
		.tcpHeaderEnd (tcpHeaderEnd),
		.sessionHit   (sessionHit),
		.payload      (payload),
		.gapped       (gapped)
	);

endmodule

/* dv/tcpFrameModel.svh */
`ifndef TCP_FRAME_MODEL_SVH
`define TCP_FRAME_MODEL_SVH

// bytes of value, msb first
task automatic pushField(input logic [47:0] value, input int n);
	for (int i = n - 1; i >= 0; i--)
		frameQ.push_back(value[8 * i +: 8]);
endtask

task automatic pushRandom(input int n);
	for (int i = 0; i < n; i++)
		frameQ.push_back(8'(randBits(8)));
endtask

////////////////////////////////////////////////////////////////////////////
// frame builder, fills frameQ and the expected payload
////////////////////////////////////////////////////////////////////////////

task automatic buildFrame(input int kind, input logic vlan, input int ipOpt, input int tcpOpt,
		input int payLen, input logic syn, input seqNumT seq);
	macAddrT     dstMac;
	ipAddrT      srcIp;
	tcpPortT     dstPort;
	logic [15:0] totalLen;
	logic [7:0]  b;
	frameQ.delete();
	dstMac   = (kind == FRAME_BAD_MAC) ? LOCAL_MAC ^ 48'h1 : LOCAL_MAC;
	srcIp    = (kind == FRAME_BAD_IP) ? session.srcIp + 32'd1 : session.srcIp;
	dstPort  = (kind == FRAME_BAD_PORT) ? session.dstPort ^ 16'h0100 : session.dstPort;
	totalLen = 16'(40 + 4 * (ipOpt + tcpOpt) + payLen);	// ip header + tcp header + data
	pushField(dstMac, 6);
	pushRandom(6);	// source mac
	if (vlan) begin
		pushField(48'h8100, 2);
		pushRandom(2);	// TCI
	end
	pushField((kind == FRAME_ARP) ? 48'h0806 : 48'h0800, 2);
	pushField({4'h4, 4'(5 + ipOpt)}, 1);
	pushRandom(1);
	pushField(totalLen, 2);
	pushRandom(5);	// id, frag, ttl
	pushField((kind == FRAME_UDP) ? 48'd17 : 48'd6, 1);
	pushRandom(2);
	pushField(srcIp, 4);
	pushField(session.dstIp, 4);
	pushRandom(4 * ipOpt);
	pushField(session.srcPort, 2);
	pushField(dstPort, 2);
	pushField(seq, 4);
	pushRandom(4);	// ack
	pushField({4'(5 + tcpOpt), 4'h0}, 1);
	pushField(syn ? 48'h02 : 48'h10, 1);
	pushRandom(6 + 4 * tcpOpt);	// window, checksum, urgent, options
	for (int i = 0; i < payLen; i++) begin
		b = 8'(randBits(8));
		frameQ.push_back(b);
		if (kind == FRAME_GOOD) begin
			expPay.push_back(b);
			expStart.push_back(i == 0);
		end
	end
	// sequence model, only the followed session counts
	if (kind == FRAME_GOOD) begin
		if (syn) begin
			modelSeq = seq + 32'd1;
			modelGap = 1'b0;
		end else begin
			modelGap = seq != modelSeq;
		end
		modelSeq = modelSeq + 32'(payLen);
	end
endtask

`endif

/* dv/tcpStreamTb.sv */
`timescale 1ns/1ps

module tcpStreamTb
	import netProtoPkg::*, parserPkg::*;
();

	localparam macAddrT LOCAL_MAC = 48'h02_5a_3c_11_7e_04;
	localparam int FRAME_GOOD     = 0;
	localparam int FRAME_BAD_MAC  = 1;
	localparam int FRAME_BAD_PORT = 2;
	localparam int FRAME_BAD_IP   = 3;
	localparam int FRAME_UDP      = 4;
	localparam int FRAME_ARP      = 5;
	localparam int WAIT_LIMIT     = 2000;	// cycles

	logic    CLOCK;
	logic    rst;
	logic    newPkt;
	rxByteT  rxByte;
	sessionT session;
	rxByteT  payload;
	logic    payloadStart;
	logic    gapped;

	logic [31:0] lfsr = 32'h92a2;
	logic [7:0]  frameQ[$];
	logic [7:0]  expPay[$];
	logic        expStart[$];
	logic [7:0]  gotPay[$];
	logic        gotStart[$];
	seqNumT      modelSeq;
	logic        modelGap;
	string       testName;
	int          errCount;
	int          errAtStart;
	int          testsPassed;
	int          testsFailed;

	tcpStreamTop #(.LOCAL_MAC(LOCAL_MAC)) tcpStreamTop_inst (
		.CLOCK        (CLOCK),
		.rst          (rst),
		.newPkt       (newPkt),
		.rxByte       (rxByte),
		.session      (session),
		.payload      (payload),
		.payloadStart (payloadStart),
		.gapped       (gapped)
	);

	always #5 CLOCK = ~CLOCK;

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] value;
		logic        fb;
		value = '0;
		for (int i = 0; i < n; i++) begin
			fb    = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr  = {lfsr[30:0], fb};
			value = {value[30:0], fb};
		end
		return value;
	endfunction

	`include "tcpFrameModel.svh"

	////////////////////////////////////////////////////////////////////////////
	// drive, collect and compare
	////////////////////////////////////////////////////////////////////////////

	task automatic driveCycle(input logic pkt, input logic valid, input logic [7:0] data);
		@(posedge CLOCK);
		#1;
		newPkt = pkt;
		rxByte = '{valid: valid, data: data};
	endtask

	task automatic compareValue(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (expected === actual)
		else begin
			$display("MISMATCH %s %s expected %0h actual %0h", testName, what, expected, actual);
			errCount++;
		end
	endtask

	task automatic sendFrame(input logic idleOn);
		driveCycle(1'b1, 1'b0, 8'h00);	// frame start pulse
		foreach (frameQ[i]) begin
			if (idleOn)
				repeat (randBits(2)) driveCycle(1'b0, 1'b0, 8'h00);
			driveCycle(1'b0, 1'b1, frameQ[i]);
		end
		driveCycle(1'b0, 1'b0, 8'h00);
		repeat (2) @(negedge CLOCK);
		compareValue("gapped", modelGap, gapped);
	endtask

	always @(negedge CLOCK) begin
		if (!rst && payload.valid) begin
			gotPay.push_back(payload.data);
			gotStart.push_back(payloadStart);
		end
	end

	task automatic waitPayload(input int count);
		int n;
		n = 0;
		while (gotPay.size() < count && n < WAIT_LIMIT) begin
			@(negedge CLOCK);
			n++;
		end
		assert (gotPay.size() >= count)
		else begin
			$display("%s: timed out waiting for %0d payload bytes, only %0d arrived",
				testName, count, gotPay.size());
			errCount++;
		end
		repeat (4) @(negedge CLOCK);	// room for stray bytes
	endtask

	task automatic startTest(input string name);
		testName   = name;
		errAtStart = errCount;
		expPay.delete();
		expStart.delete();
		gotPay.delete();
		gotStart.delete();
	endtask

	task automatic endTest();
		compareValue("payload count", expPay.size(), gotPay.size());
		foreach (expPay[i]) begin
			if (i < gotPay.size()) begin
				compareValue("payload byte", expPay[i], gotPay[i]);
				compareValue("payloadStart", expStart[i], gotStart[i]);
			end
		end
		if (errCount == errAtStart) begin
			testsPassed++;
			$display("test %s: passed", testName);
		end else begin
			testsFailed++;
			$display("test %s: failed with %0d errors", testName, errCount - errAtStart);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		int     kinds[9];
		int     ipOpt;
		int     tcpOpt;
		int     payLen;
		logic   vlan;
		seqNumT synSeq;
		CLOCK       = 1'b0;
		rst         = 1'b1;
		newPkt      = 1'b0;
		rxByte      = '0;
		modelSeq    = '0;
		modelGap    = 1'b0;
		errCount    = 0;
		testsPassed = 0;
		testsFailed = 0;
		session.srcIp   = randBits(32);
		session.dstIp   = randBits(32);
		session.srcPort = 16'(randBits(16));
		session.dstPort = 16'(randBits(16));
		kinds = '{FRAME_GOOD, FRAME_BAD_MAC, FRAME_GOOD, FRAME_BAD_PORT, FRAME_BAD_IP,
			FRAME_GOOD, FRAME_UDP, FRAME_ARP, FRAME_GOOD};
		repeat (5) @(posedge CLOCK);
		#1;
		rst = 1'b0;

		startTest("reset");
		for (int i = 0; i < 20; i++) begin
			@(negedge CLOCK);
			compareValue("payload.valid", 1'b0, payload.valid);
			compareValue("payloadStart", 1'b0, payloadStart);
			compareValue("gapped", 1'b0, gapped);
		end
		endTest();

		startTest("plainFrame");
		payLen = 8 + randBits(4);
		buildFrame(FRAME_GOOD, 1'b0, 0, 0, payLen, 1'b0, modelSeq);
		sendFrame(1'b0);
		waitPayload(expPay.size());
		endTest();

		// both option runs and a vlan tag, then again with idle gaps
		for (int pass = 0; pass < 2; pass++) begin
			startTest(pass == 0 ? "optionFrames" : "idleGaps");
			for (int f = 0; f < 4; f++) begin
				ipOpt  = randBits(3);
				tcpOpt = randBits(3);
				payLen = 1 + randBits(6);
				buildFrame(FRAME_GOOD, 1'b1, ipOpt, tcpOpt, payLen, 1'b0, modelSeq);
				sendFrame(pass == 1);
			end
			waitPayload(expPay.size());
			endTest();
		end

		startTest("filterMix");
		foreach (kinds[i]) begin
			vlan   = randBits(1);
			tcpOpt = randBits(2);
			payLen = 4 + randBits(4);
			buildFrame(kinds[i], vlan, 0, tcpOpt, payLen, 1'b0, modelSeq);
			sendFrame(1'b0);
		end
		waitPayload(expPay.size());
		endTest();

		startTest("sequence");
		synSeq = randBits(32);
		buildFrame(FRAME_GOOD, 1'b0, 0, 0, 0, 1'b1, synSeq);
		sendFrame(1'b0);
		buildFrame(FRAME_GOOD, 1'b0, 0, 1, 6, 1'b0, modelSeq);
		sendFrame(1'b0);
		compareValue("gap after in-order data", 1'b0, gapped);
		buildFrame(FRAME_GOOD, 1'b0, 0, 0, 6, 1'b0, modelSeq + 32'd100);	// skips ahead
		sendFrame(1'b0);
		compareValue("gap after skipped data", 1'b1, gapped);
		waitPayload(expPay.size());
		endTest();

		$display("summary: %0d tests passed, %0d tests failed, %0d errors",
			testsPassed, testsFailed, errCount);
		if (testsFailed == 0 && errCount == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+dv
source/netProtoPkg.sv
source/parserPkg.sv
source/frameParser.sv
source/headerCounter.sv
source/sessionFilter.sv
source/seqTracker.sv
source/tcpStreamTop.sv
dv/tcpStreamTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tcpStreamTb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= ALL TESTS PASSED

SIM := $(BUILD_DIR)/V$(TOP)
SRCS := $(wildcard source/*.sv) $(wildcard dv/*.sv) $(wildcard dv/*.svh)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
